/* source/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Memory bus widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32

// Address of the first instruction fetched after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

/* source/mem_pkg.sv */
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_DATA_WIDTH-1:0] word_t;
    typedef logic [`MEM_DATA_WIDTH/8-1:0] byte_en_t;   // One bit per byte lane

    // What a unit offers to the arbiter
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    addr;
        byte_en_t byte_enable;
        word_t    write_data;
    } mem_req_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_REQ,
        LOAD_WAIT
    } load_state_t;

    typedef enum logic {
        STORE_IDLE,
        STORE_REQ
    } store_state_t;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_FULL
    } fetch_state_t;

endpackage

`default_nettype wire

/* source/load_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module load_unit
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,

    output logic          read_ready,
    input  wire logic     read_req,
    input  wire addr_t    read_addr,
    input  wire byte_en_t read_byte_enable,
    output word_t         read_data,
    output logic          read_data_valid,

    input  wire logic     mem_ready,
    output mem_req_t      mem_req,
    input  wire word_t    mem_read_data,
    input  wire logic     mem_read_data_valid
);

    load_state_t state;
    addr_t       addr_q;
    byte_en_t    be_q;
    word_t       masked;
    int unsigned lane;                                  // Lowest enabled lane

    assign read_ready = (state == LOAD_IDLE);

    always_comb begin
        mem_req             = '0;
        mem_req.read        = (state == LOAD_REQ);
        mem_req.addr        = addr_q;
        mem_req.byte_enable = be_q;
    end

    // Keep the enabled lanes, then find how far down they must move
    always_comb begin
        masked = '0;
        lane   = 0;
        for (int i = $bits(byte_en_t) - 1; i >= 0; i--) begin
            if (be_q[i]) begin
                masked[i*8 +: 8] = mem_read_data[i*8 +: 8];
                lane             = i;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= LOAD_IDLE;
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= 1'b0;
            case (state)
                LOAD_IDLE: if (read_req) state <= LOAD_REQ;
                LOAD_REQ:  if (mem_ready) state <= LOAD_WAIT;   // Read granted
                LOAD_WAIT: begin
                    if (mem_read_data_valid) begin
                        read_data_valid <= 1'b1;
                        state           <= LOAD_IDLE;
                    end
                end
                default:   state <= LOAD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_ready && read_req) begin
            addr_q <= read_addr;
            be_q   <= read_byte_enable;
        end
        if (state == LOAD_WAIT && mem_read_data_valid)
            read_data <= masked >> (8 * lane);          // Zero filled from the top
    end

endmodule

`default_nettype wire

/* source/store_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module store_unit
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,

    output logic          write_ready,
    input  wire logic     write_req,
    input  wire addr_t    write_addr,
    input  wire word_t    write_data,
    input  wire byte_en_t write_byte_enable,

    input  wire logic     mem_ready,
    output mem_req_t      mem_req
);

    store_state_t state;
    addr_t        addr_q;
    byte_en_t     be_q;
    word_t        data_q;
    int unsigned  lane;

    assign write_ready = (state == STORE_IDLE);

    // Lowest enabled lane of the incoming store
    always_comb begin
        lane = 0;
        for (int i = $bits(byte_en_t) - 1; i >= 0; i--) begin
            if (write_byte_enable[i])
                lane = i;
        end
    end

    always_comb begin
        mem_req             = '0;
        mem_req.write       = (state == STORE_REQ);
        mem_req.addr        = addr_q;
        mem_req.byte_enable = be_q;
        mem_req.write_data  = data_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= STORE_IDLE;
        end else begin
            case (state)
                STORE_IDLE: if (write_req) state <= STORE_REQ;
                STORE_REQ:  if (mem_ready) state <= STORE_IDLE;
                default:    state <= STORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_ready && write_req) begin
            addr_q <= {write_addr[$bits(addr_t)-1:2], 2'b00};   // Word aligned on the bus
            be_q   <= write_byte_enable;
            data_q <= write_data << (8 * lane);
        end
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module fetch_unit
    import mem_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,

    output word_t      instr,
    output addr_t      instr_pc,
    output logic       instr_valid,
    input  wire logic  instr_ready,
    input  wire logic  redirect,
    input  wire addr_t redirect_pc,

    input  wire logic  mem_ready,
    output mem_req_t   mem_req,
    input  wire word_t mem_read_data,
    input  wire logic  mem_read_data_valid
);

    fetch_state_t state;
    addr_t        pc;
    logic         fetch_en;                             // Low only until the first edge
    logic         drop;                                 // Outstanding word is stale
    logic         granted;

    assign instr_valid = (state == FETCH_FULL);
    assign instr_pc    = pc;
    assign granted     = mem_req.read && mem_ready;

    always_comb begin
        mem_req             = '0;
        mem_req.read        = (state == FETCH_REQ) && fetch_en;
        mem_req.addr        = pc;
        mem_req.byte_enable = '1;                       // Always a full word
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= FETCH_REQ;
            fetch_en <= 1'b0;
            drop     <= 1'b0;
            pc       <= `FETCH_RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
                case (state)
                    FETCH_REQ: begin
                        if (granted) begin
                            drop  <= 1'b1;
                            state <= FETCH_WAIT;
                        end
                    end
                    FETCH_WAIT: begin
                        drop <= !mem_read_data_valid;   // Wait out the old read
                        if (mem_read_data_valid)
                            state <= FETCH_REQ;
                    end
                    default: state <= FETCH_REQ;
                endcase
            end else begin
                case (state)
                    FETCH_REQ: if (granted) state <= FETCH_WAIT;
                    FETCH_WAIT: begin
                        if (mem_read_data_valid) begin
                            drop  <= 1'b0;
                            state <= drop ? FETCH_REQ : FETCH_FULL;
                        end
                    end
                    FETCH_FULL: begin
                        if (instr_ready) begin
                            pc    <= pc + addr_t'(4);
                            state <= FETCH_REQ;
                        end
                    end
                    default: state <= FETCH_REQ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && mem_read_data_valid && !drop)
            instr <= mem_read_data;
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_arbiter
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,

    input  wire mem_req_t load_req,
    input  wire mem_req_t store_req,
    input  wire mem_req_t fetch_req,
    output logic          load_grant,
    output logic          store_grant,
    output logic          fetch_grant,

    input  wire logic     mem_ready,
    input  wire logic     mem_read_data_valid,
    output addr_t         mem_addr,
    output word_t         mem_write_data,
    output byte_en_t      mem_byte_enable,
    output logic          mem_read_req,
    output logic          mem_write_req
);

    logic     read_pending;
    logic     load_go;
    logic     store_go;
    logic     fetch_go;
    mem_req_t sel;

    // A read may only go out when no read data is still owed
    assign load_go  = load_req.write  || (load_req.read  && !read_pending);
    assign store_go = store_req.write || (store_req.read && !read_pending);
    assign fetch_go = fetch_req.write || (fetch_req.read && !read_pending);

    always_comb begin
        sel         = '0;                               // Idle bus
        load_grant  = 1'b0;
        store_grant = 1'b0;
        fetch_grant = 1'b0;
        if (load_go) begin
            sel        = load_req;
            load_grant = mem_ready;
        end else if (store_go) begin
            sel         = store_req;
            store_grant = mem_ready;
        end else if (fetch_go) begin
            sel         = fetch_req;
            fetch_grant = mem_ready;
        end
    end

    assign mem_addr        = sel.addr;
    assign mem_write_data  = sel.write_data;
    assign mem_byte_enable = sel.byte_enable;
    assign mem_read_req    = sel.read;
    assign mem_write_req   = sel.write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_pending <= 1'b0;
        end else begin
            if (mem_read_data_valid)
                read_pending <= 1'b0;
            if (mem_read_req && mem_ready)
                read_pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/cpu_mem_interface.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_mem_interface
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,

    output logic          read_ready,
    input  wire logic     read_req,
    input  wire addr_t    read_addr,
    input  wire byte_en_t read_byte_enable,
    output word_t         read_data,
    output logic          read_data_valid,

    output logic          write_ready,
    input  wire logic     write_req,
    input  wire addr_t    write_addr,
    input  wire word_t    write_data,
    input  wire byte_en_t write_byte_enable,

    output word_t         instr,
    output addr_t         instr_pc,
    output logic          instr_valid,
    input  wire logic     instr_ready,
    input  wire logic     redirect,
    input  wire addr_t    redirect_pc,

    input  wire logic     mem_ready,
    output addr_t         mem_addr,
    output word_t         mem_write_data,
    output byte_en_t      mem_byte_enable,
    output logic          mem_write_req,
    output logic          mem_read_req,
    input  wire word_t    mem_read_data,
    input  wire logic     mem_read_data_valid
);

    mem_req_t load_req;
    mem_req_t store_req;
    mem_req_t fetch_req;
    logic     load_grant;
    logic     store_grant;
    logic     fetch_grant;

    load_unit u_load_unit (
        .clk                 (clk),
        .arst_n              (arst_n),
        .read_ready          (read_ready),
        .read_req            (read_req),
        .read_addr           (read_addr),
        .read_byte_enable    (read_byte_enable),
        .read_data           (read_data),
        .read_data_valid     (read_data_valid),
        .mem_ready           (load_grant),
        .mem_req             (load_req),
        .mem_read_data       (mem_read_data),
        .mem_read_data_valid (mem_read_data_valid)
    );

    store_unit u_store_unit (
        .clk                 (clk),
        .arst_n              (arst_n),
        .write_ready         (write_ready),
        .write_req           (write_req),
        .write_addr          (write_addr),
        .write_data          (write_data),
        .write_byte_enable   (write_byte_enable),
        .mem_ready           (store_grant),
        .mem_req             (store_req)
    );

    fetch_unit u_fetch_unit (
        .clk                 (clk),
        .arst_n              (arst_n),
        .instr               (instr),
        .instr_pc            (instr_pc),
        .instr_valid         (instr_valid),
        .instr_ready         (instr_ready),
        .redirect            (redirect),
        .redirect_pc         (redirect_pc),
        .mem_ready           (fetch_grant),
        .mem_req             (fetch_req),
        .mem_read_data       (mem_read_data),
        .mem_read_data_valid (mem_read_data_valid)
    );

    // Load first, then store, then fetch
    mem_arbiter u_mem_arbiter (
        .clk                 (clk),
        .arst_n              (arst_n),
        .load_req            (load_req),
        .store_req           (store_req),
        .fetch_req           (fetch_req),
        .load_grant          (load_grant),
        .store_grant         (store_grant),
        .fetch_grant         (fetch_grant),
        .mem_ready           (mem_ready),
        .mem_read_data_valid (mem_read_data_valid),
        .mem_addr            (mem_addr),
        .mem_write_data      (mem_write_data),
        .mem_byte_enable     (mem_byte_enable),
        .mem_read_req        (mem_read_req),
        .mem_write_req       (mem_write_req)
    );

endmodule

`default_nettype wire

/* verif/tb_cpu_mem_interface.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module tb_cpu_mem_interface
    import mem_pkg::*;
;

    localparam int N_OPS          = 1500;
    localparam int CYCLES_PER_OP  = 12;
    localparam int TIMEOUT_CYCLES = N_OPS * CYCLES_PER_OP + 2000;

    logic     clk;
    logic     arst_n;
    logic     read_ready;
    logic     read_req;
    addr_t    read_addr;
    byte_en_t read_byte_enable;
    word_t    read_data;
    logic     read_data_valid;
    logic     write_ready;
    logic     write_req;
    addr_t    write_addr;
    word_t    write_data;
    byte_en_t write_byte_enable;
    word_t    instr;
    addr_t    instr_pc;
    logic     instr_valid;
    logic     instr_ready;
    logic     redirect;
    addr_t    redirect_pc;
    logic     mem_ready;
    addr_t    mem_addr;
    word_t    mem_write_data;
    byte_en_t mem_byte_enable;
    logic     mem_write_req;
    logic     mem_read_req;
    word_t    mem_read_data;
    logic     mem_read_data_valid;

    word_t    mem [256];                                // Memory model
    word_t    shadow [256];                             // Reference copy
    logic     rd_busy;
    int       rd_left;
    word_t    rd_word;
    logic     load_busy;                                // Accepted, result not back
    logic     load_pend;                                // Accepted, read not granted
    mem_req_t load_exp;
    word_t    load_result;
    logic     store_pend;
    mem_req_t store_exp;
    addr_t    exp_pc;
    int       ops_issued;
    int       prio_hits;
    int       n_loads;
    int       n_stores;
    int       n_instr;
    int       n_checks;
    int       n_errors;
    int       cycle_count;
    int unsigned seed_value;

    cpu_mem_interface u_cpu_mem_interface (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    function automatic int lowest_lane(input byte_en_t be);
        int lane;
        lane = 0;
        while (lane < 3 && !be[lane])
            lane++;
        return lane;
    endfunction

    // Enabled bytes packed down from bit 0, upper bits zero
    function automatic word_t extract_load(input word_t word, input byte_en_t be);
        word_t result;
        int    pos;
        result = '0;
        pos    = 0;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[pos*8 +: 8] = word[i*8 +: 8];
                pos++;
            end
        end
        return result;
    endfunction

    function automatic byte_en_t random_mask();
        case ($urandom_range(6))
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            3:       return 4'b1000;
            4:       return 4'b0011;
            5:       return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    // Looks at the settled cycle and updates the models for the coming edge
    task automatic observe();
        logic       read_owed;
        logic [7:0] idx;
        read_owed = rd_busy || mem_read_data_valid;
        if (load_pend && store_pend && !read_owed) begin
            check(32'(mem_write_req), 32'd0, "store on the bus ahead of a waiting load");
            if (mem_ready)
                prio_hits++;
        end
        if (load_pend && !read_owed && mem_ready) begin
            check(32'(mem_read_req), 32'd1, "load read missing on the bus");
            check(mem_addr, load_exp.addr, "load address on the bus");
            check(32'(mem_byte_enable), 32'(load_exp.byte_enable), "load mask on the bus");
            load_pend = 1'b0;
        end
        if (mem_read_req && mem_ready) begin
            check(32'(read_owed), 32'd0, "second read granted while one is owed");
            rd_busy = 1'b1;
            rd_word = mem[mem_addr[9:2]];
            rd_left = 1 + $urandom_range(3);            // 1 to 4 cycles
        end
        if (read_data_valid) begin
            check(32'(load_busy), 32'd1, "load result without a load");
            check(read_data, load_result, "load data");
            load_busy = 1'b0;
            n_loads++;
        end
        if (mem_write_req && mem_ready) begin
            check(32'(store_pend), 32'd1, "bus write without a store");
            check(mem_addr, store_exp.addr, "store address on the bus");
            check(32'(mem_byte_enable), 32'(store_exp.byte_enable), "store mask on the bus");
            check(mem_write_data, store_exp.write_data, "store data on the bus");
            idx = mem_addr[9:2];
            for (int i = 0; i < 4; i++) begin
                if (mem_byte_enable[i])
                    mem[idx][i*8 +: 8] = mem_write_data[i*8 +: 8];
                if (store_exp.byte_enable[i])
                    shadow[store_exp.addr[9:2]][i*8 +: 8] = store_exp.write_data[i*8 +: 8];
            end
            check(shadow[idx], mem[idx], "shadow against memory after store");
            store_pend = 1'b0;
            n_stores++;
        end
        if (redirect) begin
            exp_pc = redirect_pc;                       // Buffered word is discarded
        end else if (instr_valid && instr_ready) begin
            check(instr_pc, exp_pc, "instruction pc");
            check(instr, shadow[instr_pc[9:2]], "instruction word");
            exp_pc = exp_pc + 32'd4;
            n_instr++;
        end
        if (read_req) begin
            check(32'(read_ready), 32'd1, "load unit not ready for a new load");
            load_busy            = 1'b1;
            load_pend            = 1'b1;
            load_exp             = '0;
            load_exp.read        = 1'b1;
            load_exp.addr        = read_addr;
            load_exp.byte_enable = read_byte_enable;
            load_result          = extract_load(shadow[read_addr[9:2]], read_byte_enable);
            ops_issued++;
        end
        if (write_req) begin
            check(32'(write_ready), 32'd1, "store unit not ready for a new store");
            store_pend            = 1'b1;
            store_exp             = '0;
            store_exp.write       = 1'b1;
            store_exp.addr        = {write_addr[31:2], 2'b00};
            store_exp.byte_enable = write_byte_enable;
            store_exp.write_data  = write_data << (8 * lowest_lane(write_byte_enable));
            ops_issued++;
        end
    endtask

    task automatic drive();
        logic [7:0] idx;
        mem_ready           = ($urandom_range(3) != 0);
        mem_read_data_valid = 1'b0;
        if (rd_busy) begin
            rd_left--;
            if (rd_left == 0) begin
                mem_read_data_valid = 1'b1;
                mem_read_data       = rd_word;
                rd_busy             = 1'b0;
            end
        end
        read_req    = 1'b0;
        write_req   = 1'b0;
        redirect    = 1'b0;
        instr_ready = ($urandom_range(1) == 1);
        if (!load_busy && !store_pend && ops_issued < N_OPS && $urandom_range(1) == 0) begin
            read_req         = 1'b1;
            read_addr        = {22'h0, 8'($urandom), 2'b00};
            read_byte_enable = random_mask();
        end
        if (!store_pend && ops_issued < N_OPS && $urandom_range(1) == 0) begin
            idx = 8'(128 + $urandom_range(127));        // Stores stay in the upper half
            if (read_req && idx == read_addr[9:2])
                idx = idx ^ 8'h01;
            else if (load_busy && idx == load_exp.addr[9:2])
                idx = idx ^ 8'h01;
            write_req         = 1'b1;
            write_addr        = {22'h0, idx, 2'b00};
            write_data        = $urandom;
            write_byte_enable = random_mask();
        end
        // Keep the fetch stream in the lower half, away from stores
        if (exp_pc >= 32'h180 || $urandom_range(31) == 0) begin
            redirect    = 1'b1;
            redirect_pc = {24'h0, 6'($urandom), 2'b00};
        end
    endtask

    initial begin
        seed_value          = $urandom(32'hac50);
        clk                 = 1'b0;
        arst_n              = 1'b1;
        read_req            = 1'b0;
        read_addr           = '0;
        read_byte_enable    = '0;
        write_req           = 1'b0;
        write_addr          = '0;
        write_data          = '0;
        write_byte_enable   = '0;
        instr_ready         = 1'b0;
        redirect            = 1'b0;
        redirect_pc         = '0;
        mem_ready           = 1'b0;
        mem_read_data       = '0;
        mem_read_data_valid = 1'b0;
        rd_busy             = 1'b0;
        rd_left             = 0;
        load_busy           = 1'b0;
        load_pend           = 1'b0;
        store_pend          = 1'b0;
        exp_pc              = `FETCH_RESET_PC;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = $urandom;
            shadow[i] = mem[i];
        end
        #1 arst_n = 1'b0;
        #1;
        check(32'(instr_valid), 32'd0, "instr_valid in reset");
        check(32'(read_data_valid), 32'd0, "read_data_valid in reset");
        check(32'(mem_write_req), 32'd0, "mem_write_req in reset");
        check(32'(mem_read_req), 32'd0, "mem_read_req in reset");
        check(32'(read_ready), 32'd1, "read_ready in reset");
        check(32'(write_ready), 32'd1, "write_ready in reset");
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        while (ops_issued < N_OPS || load_busy || store_pend) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            #1;
            drive();
        end
        check(32'(prio_hits != 0), 32'd1, "no load granted ahead of a waiting store");
        check(32'(n_instr != 0), 32'd1, "no instruction taken");
        $display("Checks: %0d, errors: %0d, loads: %0d, stores: %0d, instructions: %0d",
                 n_checks, n_errors, n_loads, n_stores, n_instr);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/mem_pkg.sv
source/load_unit.sv
source/store_unit.sv
source/fetch_unit.sv
source/mem_arbiter.sv
source/cpu_mem_interface.sv
verif/tb_cpu_mem_interface.sv

/* Makefile */
# Verilator build and run for the CPU memory interface testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_mem_interface
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= ALL TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
